//--- Makefile
VERILATOR ?= verilator
TOP ?= meshRouterTb
FILELIST ?= compile.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary -j 0
PASS_TEXT ?= NO ERRORS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

//--- arbiter/outputArbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "nocParams.svh"

module outputArbiter import nocPkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`NOC_PORTS-1:0] req,
  input  flit_t [`NOC_PORTS-1:0] headFlit,
  input  logic [`NOC_PORTS-1:0] isHead,
  input  logic                  sent,
  output logic [`NOC_PORTS-1:0] grant
);

  localparam int numPorts = `NOC_PORTS;
  localparam int stateW = numPorts + 1;
  localparam logic [stateW-1:0] idleState = stateW'(1);

  // Bit 0 is idle, bit i+1 means input i holds the output.
  logic [stateW-1:0]   state;
  logic [stateW-1:0]   nextState;
  logic [numPorts-1:0] timesUp;
  logic [numPorts-1:0] load;
  logic [numPorts-1:0] advance;

  assign grant = state[stateW-1:1];

  // ~~~~~~~~~~~~~~~~~~~~
  // Packet timers

  for (genvar i = 0; i < numPorts; i++)
  begin : gTimer
    assign load[i] = grant[i] && req[i] && isHead[i];
    assign advance[i] = grant[i] && sent;

    packetTimer timer_i (
      .clk      (clk),
      .rst      (rst),
      .headFlit (headFlit[i]),
      .load     (load[i]),
      .advance  (advance[i]),
      .timesUp  (timesUp[i])
    );
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Grant FSM

  always_comb
  begin
    int   start;
    logic hold;
    logic found;
    start = 0;
    hold = 1'b0;
    found = 1'b0;
    nextState = idleState;
    for (int k = 0; k < numPorts; k++)
    begin
      if (state[k + 1])
      begin
        start = (k + 1) % numPorts;   // Search resumes after the current owner.
        hold = req[k] && !timesUp[k];
      end
    end
    if (hold)
      nextState = state;
    else
    begin
      for (int k = 0; k < numPorts; k++)
      begin
        if (!found && req[(start + k) % numPorts])
        begin
          nextState = stateW'(1) << ((start + k) % numPorts + 1);
          found = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= idleState;
    else
      state <= nextState;
  end

endmodule

`default_nettype wire

//--- arbiter/packetTimer.sv
`timescale 1ns/1ps
`default_nettype none

`include "nocParams.svh"

module packetTimer import nocPkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  flit_t headFlit,
  input  logic  load,
  input  logic  advance,
  output logic  timesUp
);

  localparam int lenW = `NOC_LEN_W;

  logic [lenW-1:0] pktLength;
  logic [lenW-1:0] count;
  logic [lenW-1:0] nextLength;
  logic [lenW-1:0] nextCount;

  // A flit sent on the load cycle is the head, so it already counts.
  assign nextLength = load ? headFlit.body.head.length : pktLength;
  assign nextCount = load ? lenW'(advance) : count + lenW'(advance);

  // Raised on the cycle the last flit goes out.
  assign timesUp = (nextCount == nextLength);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pktLength <= '0;
      count <= '0;
    end
    else
    begin
      pktLength <= nextLength;
      count <= nextCount;
    end
  end

endmodule

`default_nettype wire

//--- bench/meshRouterTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "nocParams.svh"

module meshRouterTb import nocPkg::*; ();

  localparam int numPorts = `NOC_PORTS;
  localparam int depth = `NOC_BUF_DEPTH;
  localparam int numRows = 18;
  localparam int numTests = 6;

  typedef struct packed {
    int test;
    int src;
    int destX;
    int destY;
    int len;     // Flits, head included.
    int start;   // Cycles after the test begins.
    int hold;    // Cycles downstream keeps its credits, 0 for prompt return.
  } row_t;

  // ~~~~~~~~~~~~~~~~~~~~
  // Stimulus table

  row_t rows [numRows] = '{
    '{1, 0, 1, 1, 3, 0, 0}, '{1, 0, 1, 3, 2, 0, 0}, '{1, 0, 3, 0, 4, 0, 0},
    '{1, 0, 0, 2, 3, 0, 0}, '{1, 0, 1, 0, 2, 0, 0},
    '{2, 1, 0, 1, 5, 0, 0}, '{2, 2, 0, 1, 3, 0, 0}, '{2, 4, 0, 1, 4, 0, 0},
    '{3, 3, 2, 1, 7, 0, 30}, '{3, 0, 1, 2, 6, 0, 20},
    '{4, 0, 1, 0, 4, 0, 0}, '{4, 1, 3, 1, 5, 1, 0}, '{4, 2, 0, 3, 3, 2, 0},
    '{4, 3, 1, 3, 4, 0, 0}, '{4, 4, 1, 1, 6, 3, 0},
    '{5, 0, 1, 2, 2, 0, 12}, '{5, 2, 1, 2, 6, 0, 0}, '{5, 3, 1, 2, 3, 0, 0}
  };

  string testName [numTests] = '{"reset", "xy routing", "contention", "back-pressure",
                                 "concurrency", "contention under hold"};

  logic                 clk;
  logic                 rst;
  logic [numPorts-1:0]  inValid;
  flit_t [numPorts-1:0] inFlit;
  logic [numPorts-1:0]  inCredit;
  logic [numPorts-1:0]  outValid;
  flit_t [numPorts-1:0] outFlit;
  logic [numPorts-1:0]  outCredit;

  flit_t       sendQ [numPorts][$];
  int          sendAt [numPorts][$];   // Earliest cycle for each queued flit.
  flit_t       expQ [numPorts][$];
  int          upCredit [numPorts];
  int          pending [numPorts];     // Credits owed by the downstream model.
  int          holdUntil [numPorts];
  int          heldCnt [numPorts];
  int          injected [numPorts];
  int          creditCnt [numPorts];
  int          cyc;
  int          checks;
  int          errors;
  int          testErrors;
  int          failedTests;
  logic [31:0] lcgState;

  meshRouter dut_i (
    .clk       (clk),
    .rst       (rst),
    .inValid   (inValid),
    .inFlit    (inFlit),
    .inCredit  (inCredit),
    .outValid  (outValid),
    .outFlit   (outFlit),
    .outCredit (outCredit)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] lcgNext(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // X first, then Y; a larger Y is north.
  function automatic int xyPort(input int dx, input int dy);
    if (dx > `NOC_ROUTER_X)
      return 2;
    if (dx < `NOC_ROUTER_X)
      return 3;
    if (dy > `NOC_ROUTER_Y)
      return 1;
    if (dy < `NOC_ROUTER_Y)
      return 4;
    return 0;
  endfunction

  task automatic compareValue(input string name, input logic [31:0] want,
                              input logic [31:0] got);
    checks++;
    if (want !== got)
    begin
      $display("FAIL %s expected %h got %h", name, want, got);
      errors++;
      testErrors++;
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // One clock of upstream, downstream and scoreboard

  task automatic stepCycle();
    flit_t want;
    @(posedge clk);
    #2;
    cyc++;
    for (int d = 0; d < numPorts; d++)
    begin
      if (inCredit[d])
      begin
        upCredit[d]++;
        creditCnt[d]++;
      end
      if (outValid[d])
      begin
        pending[d]++;
        if (cyc < holdUntil[d])
          heldCnt[d]++;
        if (expQ[d].size() == 0)
        begin
          $display("Output %0d sent flit %h that no packet asked for", d, outFlit[d]);
          errors++;
          testErrors++;
        end
        else
        begin
          want = expQ[d].pop_front();
          compareValue($sformatf("outFlit[%0d]", d), 32'(want), 32'(outFlit[d]));
        end
      end
    end
    for (int d = 0; d < numPorts; d++)
    begin
      outCredit[d] = 1'b0;
      inValid[d] = 1'b0;
      inFlit[d] = '0;
      if (pending[d] > 0 && cyc >= holdUntil[d])
      begin
        outCredit[d] = 1'b1;
        pending[d]--;
      end
      if (sendQ[d].size() > 0 && cyc >= sendAt[d][0] && upCredit[d] > 0)
      begin
        inValid[d] = 1'b1;
        inFlit[d] = sendQ[d].pop_front();
        void'(sendAt[d].pop_front());
        upCredit[d]--;
        injected[d]++;
      end
    end
  endtask

  task automatic runTest(input int t);
    flit_t f;
    int    startCyc;
    int    o;
    int    busy;
    int    routed [numPorts];
    int    wantHeld;
    testErrors = 0;
    startCyc = cyc;
    for (int d = 0; d < numPorts; d++)
    begin
      holdUntil[d] = startCyc;
      heldCnt[d] = 0;
      injected[d] = 0;
      creditCnt[d] = 0;
      routed[d] = 0;
    end
    // From idle, packets that meet at one output leave in ascending input order.
    for (int s = 0; s < numPorts; s++)
    begin
      for (int r = 0; r < numRows; r++)
      begin
        if (rows[r].test == t && rows[r].src == s)
        begin
          o = xyPort(rows[r].destX, rows[r].destY);
          routed[o] += rows[r].len;
          if (startCyc + rows[r].hold > holdUntil[o])
            holdUntil[o] = startCyc + rows[r].hold;
          for (int i = 0; i < rows[r].len; i++)
          begin
            f = '0;
            if (i == 0)
            begin
              f.kind = kindHead;
              f.body.head.destX = `NOC_COORD_W'(rows[r].destX);
              f.body.head.destY = `NOC_COORD_W'(rows[r].destY);
              f.body.head.length = `NOC_LEN_W'(rows[r].len);
            end
            else
            begin
              lcgState = lcgNext(lcgState);
              f.kind = (i == rows[r].len - 1) ? kindTail : kindBody;
              f.body.data = lcgState[30:10];
            end
            sendQ[s].push_back(f);
            sendAt[s].push_back(startCyc + rows[r].start);
            expQ[o].push_back(f);
          end
        end
      end
    end
    busy = 1;
    while (busy != 0)
    begin
      stepCycle();
      busy = 0;
      for (int d = 0; d < numPorts; d++)
        busy += sendQ[d].size() + expQ[d].size() + pending[d];
    end
    repeat (4) stepCycle();   // Let the last credit pulses arrive.
    for (int d = 0; d < numPorts; d++)
    begin
      // A long hold lets an output spend exactly its initial credit.
      wantHeld = 0;
      if (holdUntil[d] > startCyc)
        wantHeld = (routed[d] > depth) ? depth : routed[d];
      compareValue($sformatf("inCredit[%0d] pulses", d), injected[d], creditCnt[d]);
      compareValue($sformatf("outValid[%0d] flits while credits held", d),
                   wantHeld, heldCnt[d]);
    end
    if (testErrors == 0)
      $display("Test %0d %s: passed", t, testName[t]);
    else
    begin
      $display("Test %0d %s: failed with %0d errors", t, testName[t], testErrors);
      failedTests++;
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // Main sequence and watchdog

  initial
  begin
    rst = 1'b1;
    inValid = '0;
    inFlit = '0;
    outCredit = '0;
    cyc = 0;
    checks = 0;
    errors = 0;
    failedTests = 0;
    lcgState = 32'd97;
    for (int d = 0; d < numPorts; d++)
    begin
      upCredit[d] = depth;
      pending[d] = 0;
      holdUntil[d] = 0;
    end
    repeat (5) @(posedge clk);
    #2;
    rst = 1'b0;
    for (int t = 0; t < numTests; t++)
      runTest(t);
    $display("Tests %0d, failed %0d, checks %0d, errors %0d",
             numTests, failedTests, checks, errors);
    if (errors == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

  initial
  begin
    int limit;
    limit = 500;
    for (int r = 0; r < numRows; r++)
      limit += rows[r].len * 40;
    repeat (limit) @(posedge clk);
    $display("Timeout: the tests did not finish within %0d cycles", limit);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

//--- common/flitLink.sv
`timescale 1ns/1ps
`default_nettype none

`include "nocParams.svh"

interface flitLink import nocPkg::*; ();

  logic [`NOC_PORTS-1:0] req;       // One-hot over the outputs.
  flit_t                 headFlit;  // Flit at the FIFO head.
  logic                  isHead;

  // Each output port drives its own bit.
  wire  [`NOC_PORTS-1:0] grant;

  modport buffer (
    output req,
    output headFlit,
    output isHead,
    input  grant
  );

  modport port (
    input  req,
    input  headFlit,
    input  isHead,
    output grant
  );

endinterface

`default_nettype wire

//--- common/nocParams.svh
`ifndef NOC_PARAMS_SVH
`define NOC_PARAMS_SVH

// ~~~~~~~~~~~~~~~~~~~~
// Router geometry

`define NOC_PORTS 5
`define NOC_BUF_DEPTH 4

// Position of this router in the mesh.
`define NOC_ROUTER_X 1
`define NOC_ROUTER_Y 1

// ~~~~~~~~~~~~~~~~~~~~
// Flit fields

`define NOC_COORD_W 2
`define NOC_LEN_W 12
`define NOC_BODY_W 21

`endif

//--- common/nocPkg.sv
`default_nettype none

`include "nocParams.svh"

package nocPkg;

  typedef enum logic [2:0] {
    kindIdle = 3'd0,
    kindHead = 3'd1,
    kindBody = 3'd2,
    kindTail = 3'd3
  } flitKind_t;

  // Doubles as output route and array index.
  typedef enum logic [2:0] {
    portLocal = 3'd0,
    portNorth = 3'd1,
    portEast  = 3'd2,
    portWest  = 3'd3,
    portSouth = 3'd4
  } portIdx_t;

  localparam int spareW = `NOC_BODY_W - 2 * `NOC_COORD_W - `NOC_LEN_W;

  typedef struct packed {
    logic [spareW-1:0]       spare;
    logic [`NOC_COORD_W-1:0] destX;
    logic [`NOC_COORD_W-1:0] destY;
    logic [`NOC_LEN_W-1:0]   length;   // Flits in packet, head included.
  } headInfo_t;

  typedef union packed {
    headInfo_t              head;
    logic [`NOC_BODY_W-1:0] data;
  } flitBody_t;

  typedef struct packed {
    flitKind_t kind;
    flitBody_t body;
  } flit_t;

endpackage

`default_nettype wire

//--- compile.f
+incdir+common
common/nocPkg.sv
common/flitLink.sv
source/inputBuffer.sv
arbiter/packetTimer.sv
arbiter/outputArbiter.sv
source/outputPort.sv
source/meshRouter.sv
bench/meshRouterTb.sv

//--- source/inputBuffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "nocParams.svh"

module inputBuffer import nocPkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  logic   inValid,
  input  flit_t  inFlit,
  output logic   inCredit,
  flitLink.buffer link
);

  localparam int depth = `NOC_BUF_DEPTH;
  localparam int ptrW = $clog2(depth);
  localparam int coordW = `NOC_COORD_W;
  localparam logic [coordW-1:0] hereX = coordW'(`NOC_ROUTER_X);
  localparam logic [coordW-1:0] hereY = coordW'(`NOC_ROUTER_Y);

  flit_t           mem [depth];
  logic [ptrW-1:0] wrPtr;
  logic [ptrW-1:0] rdPtr;
  logic [ptrW:0]   count;
  logic            empty;
  logic            pop;
  flit_t           frontFlit;
  logic            frontIsHead;
  portIdx_t        route;
  portIdx_t        routeReg;

  // X first, then Y. Larger Y lies to the north.
  function automatic portIdx_t xyRoute(input flit_t f);
    portIdx_t r;
    if (f.body.head.destX > hereX)
      r = portEast;
    else if (f.body.head.destX < hereX)
      r = portWest;
    else if (f.body.head.destY > hereY)
      r = portNorth;
    else if (f.body.head.destY < hereY)
      r = portSouth;
    else
      r = portLocal;
    return r;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~
  // FIFO

  assign empty = (count == '0);
  assign pop = |link.grant;   // Grant only comes with a request, so never empty.
  assign frontFlit = mem[rdPtr];

  always_ff @(posedge clk)
  begin
    if (inValid)
      mem[wrPtr] <= inFlit;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (inValid)
        wrPtr <= (wrPtr == ptrW'(depth - 1)) ? '0 : wrPtr + 1'b1;
      if (pop)
        rdPtr <= (rdPtr == ptrW'(depth - 1)) ? '0 : rdPtr + 1'b1;
      if (inValid && !pop)
        count <= count + 1'b1;
      else if (!inValid && pop)
        count <= count - 1'b1;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Routing and credit return

  assign frontIsHead = !empty && (frontFlit.kind == kindHead);
  assign route = frontIsHead ? xyRoute(frontFlit) : routeReg;   // Body flits follow the head.

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      routeReg <= portLocal;
      inCredit <= 1'b0;
    end
    else
    begin
      if (pop && frontIsHead)
        routeReg <= route;
      inCredit <= pop;   // One slot freed per pop.
    end
  end

  assign link.req = empty ? '0 : (`NOC_PORTS'(1) << route);
  assign link.headFlit = frontFlit;
  assign link.isHead = frontIsHead;

endmodule

`default_nettype wire

//--- source/meshRouter.sv
`timescale 1ns/1ps
`default_nettype none

`include "nocParams.svh"

module meshRouter import nocPkg::*; (
  input  logic                   clk,
  input  logic                   rst,

  // From upstream neighbours, indexed by portIdx_t.
  input  logic [`NOC_PORTS-1:0]  inValid,
  input  flit_t [`NOC_PORTS-1:0] inFlit,
  output logic [`NOC_PORTS-1:0]  inCredit,

  // To downstream neighbours.
  output logic [`NOC_PORTS-1:0]  outValid,
  output flit_t [`NOC_PORTS-1:0] outFlit,
  input  logic [`NOC_PORTS-1:0]  outCredit
);

  localparam int numPorts = `NOC_PORTS;

  flitLink links [numPorts] ();

  // ~~~~~~~~~~~~~~~~~~~~
  // Input side

  for (genvar d = 0; d < numPorts; d++)
  begin : gInput
    inputBuffer inBuf_i (
      .clk      (clk),
      .rst      (rst),
      .inValid  (inValid[d]),
      .inFlit   (inFlit[d]),
      .inCredit (inCredit[d]),
      .link     (links[d])
    );
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Output side

  for (genvar d = 0; d < numPorts; d++)
  begin : gOutput
    outputPort #(
      .outIndex (d)
    ) outPort_i (
      .clk       (clk),
      .rst       (rst),
      .links     (links),
      .outValid  (outValid[d]),
      .outFlit   (outFlit[d]),
      .outCredit (outCredit[d])
    );
  end

endmodule

`default_nettype wire

//--- source/outputPort.sv
`timescale 1ns/1ps
`default_nettype none

`include "nocParams.svh"

module outputPort import nocPkg::*; #(
  parameter int outIndex = 0
) (
  input  logic  clk,
  input  logic  rst,
  flitLink.port links [`NOC_PORTS],
  output logic  outValid,
  output flit_t outFlit,
  input  logic  outCredit
);

  localparam int numPorts = `NOC_PORTS;
  localparam int creditW = $clog2(`NOC_BUF_DEPTH + 1);

  logic [numPorts-1:0]  req;
  logic [numPorts-1:0]  isHead;
  flit_t [numPorts-1:0] headFlit;
  logic [numPorts-1:0]  arbGrant;
  logic [numPorts-1:0]  grantGated;
  logic [creditW-1:0]   credit;
  logic                 creditOk;
  logic                 sent;
  flit_t                sendFlit;

  // This output's column of every input link.
  for (genvar i = 0; i < numPorts; i++)
  begin : gLink
    assign req[i] = links[i].req[outIndex];
    assign isHead[i] = links[i].isHead;
    assign headFlit[i] = links[i].headFlit;
    assign links[i].grant[outIndex] = grantGated[i];
  end

  outputArbiter arb_i (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .headFlit (headFlit),
    .isHead   (isHead),
    .sent     (sent),
    .grant    (arbGrant)
  );

  // No credit stalls the packet but keeps the grant.
  assign creditOk = (credit != '0);
  assign grantGated = arbGrant & req & {numPorts{creditOk}};
  assign sent = |grantGated;

  always_comb
  begin
    sendFlit = '0;
    for (int i = 0; i < numPorts; i++)
    begin
      if (grantGated[i])
        sendFlit = headFlit[i];
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Credits and output register

  always_ff @(posedge clk)
  begin
    if (rst)
      credit <= creditW'(`NOC_BUF_DEPTH);
    else if (sent && !outCredit)
      credit <= credit - 1'b1;
    else if (!sent && outCredit)
      credit <= credit + 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      outValid <= 1'b0;
    else
      outValid <= sent;
  end

  always_ff @(posedge clk)
  begin
    if (sent)
      outFlit <= sendFlit;
  end

endmodule

`default_nettype wire
